// ==== design/mm_pkg.sv ====
`default_nettype none

package mm_pkg;

    // --------------------
    // bus widths
    // --------------------
    localparam int DATA_WIDTH   = 32;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH   = 8;

    // --------------------
    // memory geometry and timing
    // --------------------
    localparam int MEM_DEPTH          = 256;
    // waitrequest-high cycles before a command is taken
    localparam int SLAVE_WAIT_CYCLES  = 2;
    // accept to readdatavalid
    localparam int SLAVE_READ_LATENCY = 2;

    typedef logic [DATA_WIDTH-1:0]   mm_word_t;
    typedef logic [ADDR_WIDTH-1:0]   mm_addr_t;
    typedef logic [BYTEEN_WIDTH-1:0] mm_byteen_t;

    // one word command as it moves through the bridge
    typedef struct packed {
        mm_addr_t   address;
        mm_word_t   writedata;
        mm_byteen_t byteenable;
        logic       read;
        logic       write;
    } mm_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACCEPT
    } slave_state_t;

endpackage

`default_nettype wire

// ==== design/mm_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mm_if;
    import mm_pkg::*;

    // --------------------
    // command side
    // --------------------
    mm_addr_t   address;
    mm_word_t   writedata;
    mm_byteen_t byteenable;
    logic       read;
    logic       write;

    // --------------------
    // flow control and response
    // --------------------
    logic       waitrequest;
    mm_word_t   readdata;
    logic       readdatavalid;

    // initiator of word accesses
    modport host (
        output address, writedata, byteenable, read, write,
        input  waitrequest, readdata, readdatavalid
    );

    // target, mirror of host
    modport agent (
        input  address, writedata, byteenable, read, write,
        output waitrequest, readdata, readdatavalid
    );

endinterface

`default_nettype wire

// ==== design/mm_wait_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mm_wait_stage (
    input  logic            clk,
    input  logic            reset,
    input  mm_pkg::mm_cmd_t up,
    output logic            up_waitrequest,
    output mm_pkg::mm_cmd_t down,
    input  logic            stall
);
    import mm_pkg::*;

    // captured copy of the command presented when the stall rose
    mm_cmd_t skid_q;
    // replay the skid copy instead of the live command
    logic    use_skid;
    logic    stall_rise;

    // --------------------
    // stall edge detect
    // --------------------
    // host still saw waitrequest low this cycle, so whatever it presents
    // now counts as issued and must be kept
    assign stall_rise = ~up_waitrequest & stall;

    // --------------------
    // registered waitrequest
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // host must not issue during the first cycle out of reset
            up_waitrequest <= 1'b1;
            // skid copy holds no command after reset, so the live bus
            // is not sampled while the host sees a stale waitrequest
            use_skid       <= 1'b1;
        end else begin
            up_waitrequest <= stall;
            if (!stall) begin
                // downstream took the replayed command
                use_skid <= 1'b0;
            end else if (stall_rise) begin
                use_skid <= 1'b1;
            end
        end
    end

    // --------------------
    // skid register
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            skid_q <= '{address: '0, writedata: '0, byteenable: '1,
                        read: 1'b0, write: 1'b0};
        end else if (stall_rise) begin
            skid_q <= up;
        end
    end

    // live command unless a stalled one is being replayed
    always_comb begin
        down = up;
        if (use_skid) begin
            down = skid_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/mm_cmd_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mm_cmd_stage (
    input  logic            clk,
    input  logic            reset,
    input  mm_pkg::mm_cmd_t up,
    output logic            stall,
    mm_if.host              down
);
    import mm_pkg::*;

    // command currently offered downstream
    mm_cmd_t cmd_q;
    logic    cmd_busy;

    // --------------------
    // stall generation
    // --------------------
    assign cmd_busy = cmd_q.read | cmd_q.write;
    // an empty register can always take the next command
    assign stall    = down.waitrequest & cmd_busy;

    // --------------------
    // command register
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // idle, all lanes enabled
            cmd_q <= '{address: '0, writedata: '0, byteenable: '1,
                       read: 1'b0, write: 1'b0};
        end else if (!stall) begin
            // previous command accepted or none held
            cmd_q <= up;
        end
    end

    // drive the downstream bus straight from the register
    assign down.address    = cmd_q.address;
    assign down.writedata  = cmd_q.writedata;
    assign down.byteenable = cmd_q.byteenable;
    assign down.read       = cmd_q.read;
    assign down.write      = cmd_q.write;

endmodule

`default_nettype wire

// ==== design/mm_pipeline_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module mm_pipeline_bridge #(
    parameter bit PIPELINE_COMMAND  = 1'b1,
    parameter bit PIPELINE_RESPONSE = 1'b1
) (
    input  logic clk,
    input  logic reset,
    mm_if.agent  up,
    mm_if.host   down
);
    import mm_pkg::*;

    mm_cmd_t up_cmd;

    // gather the host command fields
    assign up_cmd = '{address: up.address, writedata: up.writedata,
                      byteenable: up.byteenable, read: up.read, write: up.write};

    // --------------------
    // command path
    // --------------------
    if (PIPELINE_COMMAND) begin : g_cmd_pipe
        mm_cmd_t wait_cmd;
        logic    cmd_stall;

        // skid stage registers waitrequest toward the host
        mm_wait_stage u_wait (
            .clk            (clk),
            .reset          (reset),
            .up             (up_cmd),
            .up_waitrequest (up.waitrequest),
            .down           (wait_cmd),
            .stall          (cmd_stall)
        );

        // register stage drives the downstream bus
        mm_cmd_stage u_cmd (
            .clk   (clk),
            .reset (reset),
            .up    (wait_cmd),
            .stall (cmd_stall),
            .down  (down)
        );
    end else begin : g_cmd_bypass
        // zero-cycle command path
        assign down.address    = up_cmd.address;
        assign down.writedata  = up_cmd.writedata;
        assign down.byteenable = up_cmd.byteenable;
        assign down.read       = up_cmd.read;
        assign down.write      = up_cmd.write;
        assign up.waitrequest  = down.waitrequest;
    end

    // --------------------
    // response path
    // --------------------
    if (PIPELINE_RESPONSE) begin : g_rsp_reg
        mm_word_t rsp_data_q;
        logic     rsp_valid_q;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                rsp_valid_q <= 1'b0;
            end else begin
                rsp_valid_q <= down.readdatavalid;
            end
        end

        // data only matters alongside valid
        always_ff @(posedge clk) begin
            if (down.readdatavalid) begin
                rsp_data_q <= down.readdata;
            end
        end

        assign up.readdata      = rsp_data_q;
        assign up.readdatavalid = rsp_valid_q;
    end else begin : g_rsp_bypass
        assign up.readdata      = down.readdata;
        assign up.readdatavalid = down.readdatavalid;
    end

endmodule

`default_nettype wire

// ==== design/mm_sram_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module mm_sram_slave (
    input  logic clk,
    input  logic reset,
    mm_if.agent  bus
);
    import mm_pkg::*;

    typedef logic [$clog2(SLAVE_WAIT_CYCLES+1)-1:0] wait_cnt_t;

    slave_state_t state;
    wait_cnt_t    wait_cnt;
    logic         cmd_present;
    logic         accept;

    mm_word_t     mem [MEM_DEPTH];

    // read latency pipeline, index 0 is the accept stage
    logic [SLAVE_READ_LATENCY-1:0] rd_valid_q;
    mm_word_t                      rd_data_q [SLAVE_READ_LATENCY];

    assign cmd_present = bus.read | bus.write;
    // host holds the command, so ST_ACCEPT always sees it
    assign accept      = (state == ST_ACCEPT) & cmd_present;

    // high from the first cycle a command shows until ST_ACCEPT
    assign bus.waitrequest = (state == ST_WAIT) | ((state == ST_IDLE) & cmd_present);

    // --------------------
    // wait state FSM
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // this cycle already counts as one wait cycle
                    if (cmd_present) begin
                        wait_cnt <= wait_cnt_t'(1);
                        state    <= (SLAVE_WAIT_CYCLES > 1) ? ST_WAIT : ST_ACCEPT;
                    end
                end
                ST_WAIT: begin
                    if (wait_cnt == wait_cnt_t'(SLAVE_WAIT_CYCLES - 1)) begin
                        state <= ST_ACCEPT;
                    end else begin
                        wait_cnt <= wait_cnt + wait_cnt_t'(1);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (accept && bus.write) begin
            // merge per byte lane
            for (int b = 0; b < BYTEEN_WIDTH; b++) begin
                if (bus.byteenable[b]) begin
                    mem[bus.address][b*8 +: 8] <= bus.writedata[b*8 +: 8];
                end
            end
        end
    end

    // --------------------
    // read latency
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q[0] <= accept & bus.read;
            for (int i = 1; i < SLAVE_READ_LATENCY; i++) begin
                rd_valid_q[i] <= rd_valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && bus.read) begin
            rd_data_q[0] <= mem[bus.address];
        end
        for (int i = 1; i < SLAVE_READ_LATENCY; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    assign bus.readdatavalid = rd_valid_q[SLAVE_READ_LATENCY-1];
    assign bus.readdata      = rd_data_q[SLAVE_READ_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/mm_bridge_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mm_bridge_top (
    input  logic               clk,
    input  logic               reset,
    input  mm_pkg::mm_addr_t   host_address,
    input  mm_pkg::mm_word_t   host_writedata,
    input  mm_pkg::mm_byteen_t host_byteenable,
    input  logic               host_read,
    input  logic               host_write,
    output logic               host_waitrequest,
    output mm_pkg::mm_word_t   host_readdata,
    output logic               host_readdatavalid
);

    // host side and memory side of the bridge
    mm_if up_bus ();
    mm_if down_bus ();

    // --------------------
    // host port mapping
    // --------------------
    assign up_bus.address    = host_address;
    assign up_bus.writedata  = host_writedata;
    assign up_bus.byteenable = host_byteenable;
    assign up_bus.read       = host_read;
    assign up_bus.write      = host_write;

    assign host_waitrequest   = up_bus.waitrequest;
    assign host_readdata      = up_bus.readdata;
    assign host_readdatavalid = up_bus.readdatavalid;

    // both pipeline options on
    mm_pipeline_bridge #(
        .PIPELINE_COMMAND  (1'b1),
        .PIPELINE_RESPONSE (1'b1)
    ) u_bridge (
        .clk   (clk),
        .reset (reset),
        .up    (up_bus.agent),
        .down  (down_bus.host)
    );

    mm_sram_slave u_sram (
        .clk   (clk),
        .reset (reset),
        .bus   (down_bus.agent)
    );

endmodule

`default_nettype wire

// ==== verif/tb_mm_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mm_bridge;
    import mm_pkg::*;

    // --------------------
    // run length
    // --------------------
    localparam int FILL_OPS   = MEM_DEPTH;
    localparam int FULL_OPS   = 64;
    localparam int LANE_OPS   = 32;
    localparam int B2B_OPS    = 48;
    localparam int RANDOM_OPS = 250;
    localparam int TOTAL_OPS  = FILL_OPS + FULL_OPS + LANE_OPS + B2B_OPS + RANDOM_OPS;
    // budget per operation covers wait states, read latency and bridge stages
    localparam int TIMEOUT_CYCLES =
        TOTAL_OPS * (SLAVE_WAIT_CYCLES + SLAVE_READ_LATENCY + 6) + 100;
    // reads still queued in the bridge and the memory return well within this
    localparam int DRAIN_CYCLES = 4 * (SLAVE_WAIT_CYCLES + SLAVE_READ_LATENCY + 6);

    logic       clk;
    logic       reset;
    mm_addr_t   host_address;
    mm_word_t   host_writedata;
    mm_byteen_t host_byteenable;
    logic       host_read;
    logic       host_write;
    logic       host_waitrequest;
    mm_word_t   host_readdata;
    logic       host_readdatavalid;

    // reference model and in-order response tracking
    mm_word_t ref_mem [MEM_DEPTH];
    mm_word_t expected_q [$];
    mm_addr_t addr_q [$];
    int       error_count;
    int       reads_issued;
    int       rvalid_count;
    int       cycle_count;
    integer   seed;
    string    cur_test;

    mm_bridge_top uut (
        .clk                (clk),
        .reset              (reset),
        .host_address       (host_address),
        .host_writedata     (host_writedata),
        .host_byteenable    (host_byteenable),
        .host_read          (host_read),
        .host_write         (host_write),
        .host_waitrequest   (host_waitrequest),
        .host_readdata      (host_readdata),
        .host_readdatavalid (host_readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // reference helpers
    // --------------------
    // new word after a write with lane mask be
    function automatic mm_word_t merge_word(mm_word_t old, mm_word_t data, mm_byteen_t be);
        mm_word_t result;
        result = old;
        for (int b = 0; b < BYTEEN_WIDTH; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // initial contents, every address bit shows up in the word
    function automatic mm_word_t fill_word(mm_addr_t a);
        return {a, ~a, a ^ 8'h5a, a + 8'h3c};
    endfunction

    task automatic check_word(input string name, input mm_word_t expected,
                              input mm_word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // --------------------
    // host driver
    // --------------------
    // called at a rising edge, returns at the edge that accepts the command
    task automatic issue_cmd(input logic is_write, input mm_addr_t addr,
                             input mm_word_t data, input mm_byteen_t be);
        logic stalled;
        host_address    <= addr;
        host_writedata  <= data;
        host_byteenable <= be;
        host_read       <= ~is_write;
        host_write      <= is_write;
        stalled = 1'b1;
        while (stalled) begin
            // waitrequest is settled mid cycle
            @(negedge clk);
            stalled = (host_waitrequest !== 1'b0);
            @(posedge clk);
        end
        if (is_write) begin
            ref_mem[addr] = merge_word(ref_mem[addr], data, be);
        end else begin
            expected_q.push_back(ref_mem[addr]);
            addr_q.push_back(addr);
            reads_issued++;
        end
    endtask

    task automatic go_idle;
        host_read  <= 1'b0;
        host_write <= 1'b0;
    endtask

    // wait for all reads to return, then leave room for stray pulses
    task automatic wait_drain;
        int n;
        n = 0;
        go_idle();
        while (expected_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(posedge clk);
            n++;
        end
        repeat (SLAVE_WAIT_CYCLES + SLAVE_READ_LATENCY + 4) @(posedge clk);
    endtask

    // --------------------
    // response checker
    // --------------------
    always @(negedge clk) begin
        mm_word_t exp_word;
        mm_addr_t exp_addr;
        if (!reset && host_readdatavalid === 1'b1) begin
            rvalid_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("readdatavalid seen with no read outstanding, data %h",
                         host_readdata);
            end else begin
                exp_word = expected_q.pop_front();
                exp_addr = addr_q.pop_front();
                check_word($sformatf("%s read of %h", cur_test, exp_addr),
                           exp_word, host_readdata);
            end
        end
    end

    // --------------------
    // timeout
    // --------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles, %0d reads outstanding",
                     TIMEOUT_CYCLES, expected_q.size());
            $display("errors %0d, reads %0d, responses %0d",
                     error_count + 1, reads_issued, rvalid_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // --------------------
    // test sequences
    // --------------------
    task automatic check_reset_state;
        logic fell;
        int   n;
        fell = 1'b0;
        n = 0;
        cur_test = "reset";
        while (!fell && n < 8) begin
            @(negedge clk);
            if (host_readdatavalid !== 1'b0) begin
                error_count++;
                $display("readdatavalid not low after reset");
            end
            if (n == 0 && host_waitrequest !== 1'b1) begin
                error_count++;
                $display("waitrequest not high in the first cycle after reset");
            end
            fell = (host_waitrequest === 1'b0);
            n++;
        end
        if (!fell) begin
            error_count++;
            $display("waitrequest stayed high after reset with no command issued");
        end
        @(posedge clk);
    endtask

    task automatic fill_memory;
        cur_test = "fill";
        for (int i = 0; i < FILL_OPS; i++) begin
            issue_cmd(1'b1, mm_addr_t'(i), fill_word(mm_addr_t'(i)), '1);
        end
        wait_drain();
    endtask

    task automatic full_word_writes;
        logic [31:0] r;
        cur_test = "full_word";
        for (int i = 0; i < FULL_OPS / 2; i++) begin
            r = $random(seed);
            issue_cmd(1'b1, mm_addr_t'(i * 3), r, '1);
        end
        for (int i = 0; i < FULL_OPS / 2; i++) begin
            issue_cmd(1'b0, mm_addr_t'(i * 3), '0, '1);
        end
        wait_drain();
    endtask

    // masks 0 to 15 cover single lanes and mixed lanes
    task automatic byte_lane_writes;
        logic [31:0] r;
        cur_test = "byte_lane";
        for (int i = 0; i < LANE_OPS / 2; i++) begin
            r = $random(seed);
            issue_cmd(1'b1, mm_addr_t'(100 + i), r, mm_byteen_t'(i));
            issue_cmd(1'b0, mm_addr_t'(100 + i), '0, '1);
        end
        wait_drain();
    endtask

    task automatic back_to_back;
        logic [31:0] r;
        int          reads_before;
        int          rvalid_before;
        cur_test = "back_to_back";
        reads_before  = reads_issued;
        rvalid_before = rvalid_count;
        // no idle cycle between commands
        for (int i = 0; i < B2B_OPS / 3; i++) begin
            r = $random(seed);
            issue_cmd(1'b1, mm_addr_t'(160 + i), r, mm_byteen_t'(i | 1));
            issue_cmd(1'b0, mm_addr_t'(160 + i), '0, '1);
            issue_cmd(1'b0, mm_addr_t'(159 + i), '0, '1);
        end
        wait_drain();
        check_count("back_to_back readdatavalid pulses",
                    reads_issued - reads_before, rvalid_count - rvalid_before);
    endtask

    task automatic random_ops;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        cur_test = "random";
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op = $random(seed);
            a  = $random(seed);
            d  = $random(seed);
            m  = $random(seed);
            issue_cmd(op[0], a[ADDR_WIDTH-1:0], d, m[BYTEEN_WIDTH-1:0]);
            // occasional gap between commands
            if (op[3:1] == 3'd0) begin
                go_idle();
                @(posedge clk);
            end
        end
        wait_drain();
        check_count("random response queue left", 0, expected_q.size());
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        seed            = 82;
        error_count     = 0;
        reads_issued    = 0;
        rvalid_count    = 0;
        cycle_count     = 0;
        cur_test        = "init";
        reset           = 1'b1;
        host_address    = '0;
        host_writedata  = '0;
        host_byteenable = '0;
        host_read       = 1'b0;
        host_write      = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        check_reset_state();
        fill_memory();
        full_word_writes();
        byte_lane_writes();
        back_to_back();
        random_ops();

        check_count("total readdatavalid pulses", reads_issued, rvalid_count);
        $display("errors %0d, reads %0d, responses %0d",
                 error_count, reads_issued, rvalid_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/mm_pkg.sv
design/mm_if.sv
design/mm_wait_stage.sv
design/mm_cmd_stage.sv
design/mm_pipeline_bridge.sv
design/mm_sram_slave.sv
design/mm_bridge_top.sv
verif/tb_mm_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mm_bridge -f all.f \
    -o sim_mm_bridge > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mm_bridge > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench reports its result as a line of its own
if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
